/* tb.f */
+incdir+tb
verilog/axi_mem_pkg.sv
verilog/mem_req_if.sv
verilog/axi_port_frontend.sv
verilog/shared_mem_core.sv
verilog/axi_dual_mem.sv
tb/tb_axi_dual_mem.sv

/* tb/tb_axi_tasks.svh */
// AXI bus tasks, xorshift and reference model for the dual-port memory testbench
// Included into the testbench module; index 0 is the instruction port, 1 the data port
// Every wait gives up after WAIT_LIMIT cycles and ends the run
`ifndef TB_AXI_TASKS_SVH
`define TB_AXI_TASKS_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// AXI lane placement for a transfer of 1, 2 or 4 bytes
function automatic logic [3:0] lane_mask(input logic [2:0] size, input logic [31:0] addr);
    case (size)
        3'd0:    lane_mask = 4'b0001 << addr[1:0];
        3'd1:    lane_mask = addr[1] ? 4'b1100 : 4'b0011;
        default: lane_mask = 4'b1111;
    endcase
endfunction

function automatic logic [31:0] lane_bits(input logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
endfunction

task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
    chk_cnt++;
    assert (got === exp) else begin
        err_cnt++;
        $display("ERR %0t: %s, got %h expected %h", $time, what, got, exp);
    end
endtask

task automatic give_up(input string what, input int p);
    tmo_cnt++;
    $display("Timeout at %0t: port %0d never completed the %s", $time, p, what);
    finish_run();
endtask

// --------------------
// Reference model
// --------------------
task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] data, input logic [3:0] strb,
                           output logic [1:0] resp);
    logic [3:0]             m;
    axi_mem_pkg::mem_word_u d;
    axi_mem_pkg::mem_word_u w;
    m = lane_mask(size, addr) & strb;
    d.word = data;
    resp = axi_mem_pkg::RESP_OKAY;
    if (addr < axi_mem_pkg::MEM_WORDS * 4) begin
        w = model_mem[addr[11:2]];
        for (int i = 0; i < 4; i++) begin
            if (m[i]) w.bytes[i] = d.bytes[i];
        end
        model_mem[addr[11:2]] = w;
        touched[addr[11:2]] = 1'b1;
    end else if (addr == axi_mem_pkg::IRQ_ADDR) begin
        // Only the two low lanes exist in the interrupt register
        if (m[0]) irq_model[7:0] = d.bytes[0];
        if (m[1]) irq_model[15:8] = d.bytes[1];
    end else begin
        resp = axi_mem_pkg::RESP_SLVERR;
    end
endtask

task automatic model_read(input logic [31:0] addr, input logic [2:0] size,
                          output logic [31:0] data, output logic [1:0] resp);
    resp = axi_mem_pkg::RESP_OKAY;
    if (addr < axi_mem_pkg::MEM_WORDS * 4) begin
        data = model_mem[addr[11:2]].word & lane_bits(lane_mask(size, addr));
    end else if (addr == axi_mem_pkg::IRQ_ADDR) begin
        data = {16'h0000, irq_model} & lane_bits(lane_mask(size, addr));
    end else begin
        data = '0;
        resp = axi_mem_pkg::RESP_SLVERR;
    end
endtask

// --------------------
// Single AXI transfers
// --------------------
task automatic write_txn(input int p, input logic [3:0] id, input logic [31:0] addr,
                         input logic [2:0] size, input logic [31:0] data,
                         input logic [3:0] strb, input int stall,
                         output logic [3:0] got_id, output logic [1:0] got_resp);
    int n;
    int k;
    bit aw_pend;
    bit w_pend;
    bit aw_go;
    bit w_go;
    bit done;
    awvalid[p] <= 1'b1;
    awid[p]    <= id;
    awaddr[p]  <= addr;
    awsize[p]  <= size;
    wvalid[p]  <= 1'b1;
    wdata[p]   <= data;
    wstrb[p]   <= strb;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    n = 0;
    // Each valid drops on the falling edge after its beat is taken
    while (aw_pend || w_pend) begin
        aw_go = aw_pend && awready[p];
        w_go  = w_pend && wready[p];
        @(negedge clk);
        if (aw_go) begin
            awvalid[p] <= 1'b0;
            aw_pend = 1'b0;
        end
        if (w_go) begin
            wvalid[p] <= 1'b0;
            w_pend = 1'b0;
        end
        n++;
        if (n > WAIT_LIMIT) give_up("write address and data handshake", p);
    end
    // Hold bready low for the stall cycles, checking B stays put
    k = 0;
    n = 0;
    done = 1'b0;
    while (!done) begin
        if (bvalid[p]) begin
            if (k == 0) begin
                got_id   = bid[p];
                got_resp = bresp[p];
            end else begin
                check_eq({bid[p], bresp[p]}, {got_id, got_resp},
                         $sformatf("port %0d B held stable", p));
            end
            done = (k >= stall);
            k++;
        end
        if (!done) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("write response", p);
        end
    end
    bready[p] <= 1'b1;
    @(negedge clk);
    bready[p] <= 1'b0;
endtask

task automatic read_txn(input int p, input logic [3:0] id, input logic [31:0] addr,
                        input logic [2:0] size, input int stall,
                        output logic [3:0] got_id, output logic [31:0] got_data,
                        output logic [1:0] got_resp);
    int n;
    int k;
    bit done;
    arvalid[p] <= 1'b1;
    arid[p]    <= id;
    araddr[p]  <= addr;
    arsize[p]  <= size;
    n = 0;
    while (!arready[p]) begin
        @(negedge clk);
        n++;
        if (n > WAIT_LIMIT) give_up("read address handshake", p);
    end
    @(negedge clk);
    arvalid[p] <= 1'b0;
    k = 0;
    n = 0;
    done = 1'b0;
    while (!done) begin
        if (rvalid[p]) begin
            if (k == 0) begin
                got_id   = rid[p];
                got_data = rdata[p];
                got_resp = rresp[p];
            end else begin
                check_eq({rid[p], rresp[p]}, {got_id, got_resp},
                         $sformatf("port %0d R id and resp held stable", p));
                check_eq(rdata[p], got_data, $sformatf("port %0d R data held stable", p));
            end
            done = (k >= stall);
            k++;
        end
        if (!done) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) give_up("read response", p);
        end
    end
    rready[p] <= 1'b1;
    @(negedge clk);
    rready[p] <= 1'b0;
endtask

// Transfer plus comparison with the model
task automatic do_write(input int p, input logic [31:0] addr, input logic [2:0] size,
                        input logic [31:0] data, input logic [3:0] strb, input int stall);
    logic [3:0] id;
    logic [3:0] got_id;
    logic [1:0] got_resp;
    logic [1:0] exp_resp;
    id = id_ctr[p];
    id_ctr[p] = id_ctr[p] + 4'd1;
    write_txn(p, id, addr, size, data, strb, stall, got_id, got_resp);
    model_write(addr, size, data, strb, exp_resp);
    check_eq(got_id, id, $sformatf("port %0d bid for write to %h", p, addr));
    check_eq(got_resp, exp_resp, $sformatf("port %0d bresp for write to %h", p, addr));
endtask

task automatic do_read(input int p, input logic [31:0] addr, input logic [2:0] size,
                       input int stall);
    logic [3:0]  id;
    logic [3:0]  got_id;
    logic [31:0] got_data;
    logic [1:0]  got_resp;
    logic [31:0] exp_data;
    logic [1:0]  exp_resp;
    id = id_ctr[p];
    id_ctr[p] = id_ctr[p] + 4'd1;
    read_txn(p, id, addr, size, stall, got_id, got_data, got_resp);
    model_read(addr, size, exp_data, exp_resp);
    check_eq(got_id, id, $sformatf("port %0d rid for read of %h", p, addr));
    check_eq(got_resp, exp_resp, $sformatf("port %0d rresp for read of %h", p, addr));
    check_eq(got_data, exp_data, $sformatf("port %0d rdata for read of %h", p, addr));
endtask

`endif

/* tb/tb_axi_dual_mem.sv */
// Testbench for the dual-port AXI memory
// Index 0 drives the instruction port, index 1 the data port
// Only RAM words written earlier are compared since the RAM starts unknown
`default_nettype none

module tb_axi_dual_mem;

    localparam int WAIT_LIMIT = 200;
    localparam int IMEM = 0;
    localparam int DMEM = 1;

    logic clk;
    logic rst_n;
    wire  [15:0] irq_lines;

    // Testbench-driven channel signals
    logic [1:0]       awvalid, wvalid, bready, arvalid, rready;
    logic [1:0][3:0]  awid, arid, wstrb;
    logic [1:0][31:0] awaddr, araddr, wdata;
    logic [1:0][2:0]  awsize, arsize;
    // DUT-driven channel signals
    wire  [1:0]       awready, wready, bvalid, arready, rvalid;
    wire  [1:0][3:0]  bid, rid;
    wire  [1:0][1:0]  bresp, rresp;
    wire  [1:0][31:0] rdata;

    int                     chk_cnt;
    int                     err_cnt;
    int                     tmo_cnt;
    logic [31:0]            rnd;
    logic [3:0]             id_ctr [2];
    axi_mem_pkg::mem_word_u model_mem [axi_mem_pkg::MEM_WORDS];
    bit                     touched [axi_mem_pkg::MEM_WORDS];
    logic [15:0]            irq_model;

    `include "tb_axi_tasks.svh"

    axi_dual_mem i_axi_dual_mem (
        .clk          (clk),          .rst_n        (rst_n),        .irq_lines (irq_lines),
        .imem_awvalid (awvalid[0]),   .imem_awready (awready[0]),   .imem_awid (awid[0]),
        .imem_awaddr  (awaddr[0]),    .imem_awsize  (awsize[0]),
        .imem_wvalid  (wvalid[0]),    .imem_wready  (wready[0]),
        .imem_wdata   (wdata[0]),     .imem_wstrb   (wstrb[0]),
        .imem_bvalid  (bvalid[0]),    .imem_bready  (bready[0]),
        .imem_bid     (bid[0]),       .imem_bresp   (bresp[0]),
        .imem_arvalid (arvalid[0]),   .imem_arready (arready[0]),   .imem_arid (arid[0]),
        .imem_araddr  (araddr[0]),    .imem_arsize  (arsize[0]),
        .imem_rvalid  (rvalid[0]),    .imem_rready  (rready[0]),    .imem_rid  (rid[0]),
        .imem_rdata   (rdata[0]),     .imem_rresp   (rresp[0]),
        .dmem_awvalid (awvalid[1]),   .dmem_awready (awready[1]),   .dmem_awid (awid[1]),
        .dmem_awaddr  (awaddr[1]),    .dmem_awsize  (awsize[1]),
        .dmem_wvalid  (wvalid[1]),    .dmem_wready  (wready[1]),
        .dmem_wdata   (wdata[1]),     .dmem_wstrb   (wstrb[1]),
        .dmem_bvalid  (bvalid[1]),    .dmem_bready  (bready[1]),
        .dmem_bid     (bid[1]),       .dmem_bresp   (bresp[1]),
        .dmem_arvalid (arvalid[1]),   .dmem_arready (arready[1]),   .dmem_arid (arid[1]),
        .dmem_araddr  (araddr[1]),    .dmem_arsize  (arsize[1]),
        .dmem_rvalid  (rvalid[1]),    .dmem_rready  (rready[1]),    .dmem_rid  (rid[1]),
        .dmem_rdata   (rdata[1]),     .dmem_rresp   (rresp[1])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", chk_cnt, err_cnt, tmo_cnt);
        if (err_cnt == 0 && tmo_cnt == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    // Full-word read of every RAM word the model knows
    task automatic check_touched();
        for (int i = 0; i < axi_mem_pkg::MEM_WORDS; i++) begin
            if (touched[i]) do_read(IMEM, i * 4, 3'd2, 0);
        end
    endtask

    // Random traffic on one port within its own 16 words so the ports never race
    task automatic random_port(input int p, input logic [31:0] seed, input int ops);
        logic [31:0] st;
        logic [31:0] r;
        logic [31:0] addr;
        logic [2:0]  size;
        logic [1:0]  offs;
        st = seed;
        for (int i = 0; i < ops; i++) begin
            st = xorshift32(st);
            r = st;
            st = xorshift32(st);
            size = (r[11:10] == 2'd3) ? 3'd2 : {1'b0, r[11:10]};
            offs = (size == 3'd0) ? r[9:8] : (size == 3'd1) ? {r[9], 1'b0} : 2'b00;
            addr = (p * 16 + int'(r[7:4])) * 4 + int'(offs);
            if (r[0]) do_write(p, addr, size, st, r[15:12], int'(r[18:16]));
            else      do_read(p, addr, size, int'(r[18:16]));
            repeat (int'(r[21:20])) @(negedge clk);
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        int          w;
        logic [1:0]  offs;
        logic [2:0]  size;
        logic [31:0] seed0;
        logic [31:0] seed1;
        rst_n   = 1'b0;
        awvalid = '0;
        wvalid  = '0;
        bready  = '0;
        arvalid = '0;
        rready  = '0;
        awid    = '0;
        arid    = '0;
        wstrb   = '0;
        awaddr  = '0;
        araddr  = '0;
        wdata   = '0;
        awsize  = '0;
        arsize  = '0;
        chk_cnt = 0;
        err_cnt = 0;
        tmo_cnt = 0;
        rnd     = 32'd52;
        id_ctr[0] = 4'h1;
        id_ctr[1] = 4'h8;
        irq_model = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        check_eq({rvalid, bvalid}, 32'h0, "valid outputs after reset");
        check_eq(irq_lines, 32'h0, "irq_lines after reset");
        check_eq({arready, awready, wready}, 32'h3f, "ready outputs after reset");

        // Words 0 to 31 written on the data side, read back on the instruction side
        for (int i = 0; i < 32; i++) begin
            rnd = xorshift32(rnd);
            do_write(DMEM, i * 4, 3'd2, rnd, 4'hf, 0);
            do_read(IMEM, i * 4, 3'd2, 0);
        end

        // Byte and halfword writes into words 40 to 43
        for (int i = 40; i < 44; i++) begin
            rnd = xorshift32(rnd);
            do_write(DMEM, i * 4, 3'd2, rnd, 4'hf, 0);
        end
        for (int i = 0; i < 24; i++) begin
            rnd = xorshift32(rnd);
            w = 40 + int'(rnd[1:0]);
            size = {2'b00, rnd[2]};
            offs = rnd[2] ? {rnd[4], 1'b0} : rnd[4:3];
            do_write(int'(rnd[8]), w * 4 + int'(offs), size, {rnd[15:0], rnd[31:16]},
                     rnd[12:9], 0);
            do_read(IMEM, w * 4, 3'd2, 0);
        end

        // Interrupt register
        do_write(DMEM, axi_mem_pkg::IRQ_ADDR, 3'd2, 32'habcd_1234, 4'hf, 0);
        check_eq(irq_lines, irq_model, "irq_lines after word write");
        do_write(IMEM, axi_mem_pkg::IRQ_ADDR, 3'd2, 32'h0000_5600, 4'b0010, 1);
        check_eq(irq_lines, irq_model, "irq_lines after lane 1 write");
        do_write(DMEM, axi_mem_pkg::IRQ_ADDR, 3'd0, 32'h1111_22ee, 4'hf, 0);
        check_eq(irq_lines, irq_model, "irq_lines after byte write");
        do_read(IMEM, axi_mem_pkg::IRQ_ADDR, 3'd2, 0);

        // Unmapped addresses
        do_write(DMEM, axi_mem_pkg::MEM_WORDS * 4, 3'd2, 32'hdead_beef, 4'hf, 0);
        do_write(IMEM, 32'h8000_0002, 3'd1, 32'h1234_5678, 4'hf, 2);
        do_read(IMEM, axi_mem_pkg::MEM_WORDS * 4, 3'd2, 2);
        do_read(DMEM, axi_mem_pkg::IRQ_ADDR + 4, 3'd2, 0);
        check_eq(irq_lines, irq_model, "irq_lines after unmapped writes");
        check_touched();

        // Both ports at once with response back-pressure
        rnd = xorshift32(rnd);
        seed0 = rnd;
        rnd = xorshift32(rnd);
        seed1 = rnd;
        fork
            random_port(IMEM, seed0, 80);
            random_port(DMEM, seed1, 80);
        join
        check_touched();

        finish_run();
    end

endmodule

`default_nettype wire

/* verilog/axi_dual_mem.sv */
// Dual-port AXI memory for a small processor, instruction and data sides
// Single-beat transfers only; no burst, lock, cache or prot signals
`default_nettype none

module axi_dual_mem (
    input  logic                                 clk,
    input  logic                                 rst_n,
    output logic [axi_mem_pkg::IRQ_LINES-1:0]    irq_lines,
    // Instruction port
    input  logic                                 imem_awvalid,
    output logic                                 imem_awready,
    input  logic [axi_mem_pkg::ID_W-1:0]         imem_awid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]       imem_awaddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]       imem_awsize,
    input  logic                                 imem_wvalid,
    output logic                                 imem_wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]       imem_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]       imem_wstrb,
    output logic                                 imem_bvalid,
    input  logic                                 imem_bready,
    output logic [axi_mem_pkg::ID_W-1:0]         imem_bid,
    output logic [1:0]                           imem_bresp,
    input  logic                                 imem_arvalid,
    output logic                                 imem_arready,
    input  logic [axi_mem_pkg::ID_W-1:0]         imem_arid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]       imem_araddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]       imem_arsize,
    output logic                                 imem_rvalid,
    input  logic                                 imem_rready,
    output logic [axi_mem_pkg::ID_W-1:0]         imem_rid,
    output logic [axi_mem_pkg::DATA_W-1:0]       imem_rdata,
    output logic [1:0]                           imem_rresp,
    // Data port
    input  logic                                 dmem_awvalid,
    output logic                                 dmem_awready,
    input  logic [axi_mem_pkg::ID_W-1:0]         dmem_awid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]       dmem_awaddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]       dmem_awsize,
    input  logic                                 dmem_wvalid,
    output logic                                 dmem_wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]       dmem_wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]       dmem_wstrb,
    output logic                                 dmem_bvalid,
    input  logic                                 dmem_bready,
    output logic [axi_mem_pkg::ID_W-1:0]         dmem_bid,
    output logic [1:0]                           dmem_bresp,
    input  logic                                 dmem_arvalid,
    output logic                                 dmem_arready,
    input  logic [axi_mem_pkg::ID_W-1:0]         dmem_arid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]       dmem_araddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]       dmem_arsize,
    output logic                                 dmem_rvalid,
    input  logic                                 dmem_rready,
    output logic [axi_mem_pkg::ID_W-1:0]         dmem_rid,
    output logic [axi_mem_pkg::DATA_W-1:0]       dmem_rdata,
    output logic [1:0]                           dmem_rresp
);

    mem_req_if imem_if ();
    mem_req_if dmem_if ();

    // --------------------
    // Port front-ends
    // --------------------
    axi_port_frontend i_imem_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (imem_awvalid), .awready (imem_awready), .awid (imem_awid),
        .awaddr  (imem_awaddr),  .awsize  (imem_awsize),
        .wvalid  (imem_wvalid),  .wready  (imem_wready),
        .wdata   (imem_wdata),   .wstrb   (imem_wstrb),
        .bvalid  (imem_bvalid),  .bready  (imem_bready),
        .bid     (imem_bid),     .bresp   (imem_bresp),
        .arvalid (imem_arvalid), .arready (imem_arready), .arid (imem_arid),
        .araddr  (imem_araddr),  .arsize  (imem_arsize),
        .rvalid  (imem_rvalid),  .rready  (imem_rready),  .rid  (imem_rid),
        .rdata   (imem_rdata),   .rresp   (imem_rresp),
        .mem     (imem_if.port)
    );

    axi_port_frontend i_dmem_port (
        .clk     (clk),
        .rst_n   (rst_n),
        .awvalid (dmem_awvalid), .awready (dmem_awready), .awid (dmem_awid),
        .awaddr  (dmem_awaddr),  .awsize  (dmem_awsize),
        .wvalid  (dmem_wvalid),  .wready  (dmem_wready),
        .wdata   (dmem_wdata),   .wstrb   (dmem_wstrb),
        .bvalid  (dmem_bvalid),  .bready  (dmem_bready),
        .bid     (dmem_bid),     .bresp   (dmem_bresp),
        .arvalid (dmem_arvalid), .arready (dmem_arready), .arid (dmem_arid),
        .araddr  (dmem_araddr),  .arsize  (dmem_arsize),
        .rvalid  (dmem_rvalid),  .rready  (dmem_rready),  .rid  (dmem_rid),
        .rdata   (dmem_rdata),   .rresp   (dmem_rresp),
        .mem     (dmem_if.port)
    );

    // Shared RAM and interrupt register
    shared_mem_core i_mem_core (
        .clk       (clk),
        .rst_n     (rst_n),
        .ip        (imem_if.core),
        .dp        (dmem_if.core),
        .irq_lines (irq_lines)
    );

endmodule

`default_nettype wire

/* verilog/axi_mem_pkg.sv */
// Widths, address map and response codes shared by the AXI memory
// RAM occupies byte addresses 0 to MEM_WORDS*4-1; any other address errors,
// except the interrupt register
`default_nettype none

package axi_mem_pkg;

    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 32;
    localparam int STRB_W    = 4;
    localparam int ID_W      = 4;
    localparam int SIZE_W    = 3;

    localparam int MEM_WORDS = 1024;
    localparam int MEM_AW    = 10;

    localparam int IRQ_LINES = 16;
    localparam logic [ADDR_W-1:0] IRQ_ADDR = 32'hF000_0100;

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // One memory word, whole or split into byte lanes
    typedef union packed {
        logic [DATA_W-1:0]      word;
        logic [STRB_W-1:0][7:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire

/* verilog/axi_port_frontend.sv */
// Single-beat AXI slave port; no bursts, every transfer is one beat
// Sizes above a word are taken as a full word
// One read and one write may be open at once; a ready write goes to memory first
`default_nettype none

module axi_port_frontend (
    input  logic                              clk,
    input  logic                              rst_n,
    // Write address channel
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [axi_mem_pkg::ID_W-1:0]      awid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    awaddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]    awsize,
    // Write data channel
    input  logic                              wvalid,
    output logic                              wready,
    input  logic [axi_mem_pkg::DATA_W-1:0]    wdata,
    input  logic [axi_mem_pkg::STRB_W-1:0]    wstrb,
    // Write response channel
    output logic                              bvalid,
    input  logic                              bready,
    output logic [axi_mem_pkg::ID_W-1:0]      bid,
    output logic [1:0]                        bresp,
    // Read address channel
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [axi_mem_pkg::ID_W-1:0]      arid,
    input  logic [axi_mem_pkg::ADDR_W-1:0]    araddr,
    input  logic [axi_mem_pkg::SIZE_W-1:0]    arsize,
    // Read data channel
    output logic                              rvalid,
    input  logic                              rready,
    output logic [axi_mem_pkg::ID_W-1:0]      rid,
    output logic [axi_mem_pkg::DATA_W-1:0]    rdata,
    output logic [1:0]                        rresp,
    // Memory core side
    mem_req_if.port                           mem
);

    // Captured beats
    logic                             ar_busy;
    logic [axi_mem_pkg::ID_W-1:0]     ar_id;
    logic [axi_mem_pkg::ADDR_W-1:0]   ar_addr;
    logic [axi_mem_pkg::SIZE_W-1:0]   ar_size;
    logic                             aw_busy;
    logic [axi_mem_pkg::ID_W-1:0]     aw_id;
    logic [axi_mem_pkg::ADDR_W-1:0]   aw_addr;
    logic [axi_mem_pkg::SIZE_W-1:0]   aw_size;
    logic                             w_busy;
    logic [axi_mem_pkg::DATA_W-1:0]   w_data;
    logic [axi_mem_pkg::STRB_W-1:0]   w_strb;

    // Request tracking
    logic                             ar_sent;
    logic                             wr_sent;
    logic                             wait_rsp;
    logic                             wait_wr;
    logic                             hold;
    logic                             hold_wr;
    logic                             rd_need;
    logic                             wr_need;
    logic                             sel_wr;
    logic [axi_mem_pkg::STRB_W-1:0]   rd_be;
    logic [axi_mem_pkg::STRB_W-1:0]   wr_be;
    logic [axi_mem_pkg::DATA_W-1:0]   rd_lanes;

    // Byte lanes touched by a transfer of the given size at the given offset
    function automatic logic [axi_mem_pkg::STRB_W-1:0] size_be(
        input logic [axi_mem_pkg::SIZE_W-1:0] size,
        input logic [1:0]                     offs
    );
        case (size)
            3'd0:    size_be = 4'b0001 << offs;
            3'd1:    size_be = 4'b0011 << {offs[1], 1'b0};
            default: size_be = 4'b1111;
        endcase
    endfunction

    assign arready = !ar_busy;
    assign awready = !aw_busy;
    assign wready  = !w_busy;

    assign rd_need = ar_busy && !ar_sent;
    assign wr_need = aw_busy && w_busy && !wr_sent;
    // Once presented, the kind of request stays put until granted
    assign sel_wr  = hold ? hold_wr : wr_need;
    assign rd_be   = size_be(ar_size, ar_addr[1:0]);
    assign wr_be   = size_be(aw_size, aw_addr[1:0]) & w_strb;

    assign mem.req   = (rd_need || wr_need) && !wait_rsp;
    assign mem.we    = sel_wr;
    assign mem.addr  = sel_wr ? aw_addr : ar_addr;
    assign mem.be    = sel_wr ? wr_be : rd_be;
    assign mem.wdata = w_data;

    // Only the lanes of the read reach rdata
    always_comb begin
        for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
            rd_lanes[i*8 +: 8] = rd_be[i] ? mem.rdata[i*8 +: 8] : 8'h00;
        end
    end

    // --------------------
    // Channel state
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_busy  <= 1'b0;
            aw_busy  <= 1'b0;
            w_busy   <= 1'b0;
            ar_sent  <= 1'b0;
            wr_sent  <= 1'b0;
            wait_rsp <= 1'b0;
            wait_wr  <= 1'b0;
            hold     <= 1'b0;
            hold_wr  <= 1'b0;
            rvalid   <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            if (arvalid && arready) ar_busy <= 1'b1;
            if (awvalid && awready) aw_busy <= 1'b1;
            if (wvalid && wready)   w_busy  <= 1'b1;

            hold    <= mem.req && !mem.gnt;
            hold_wr <= sel_wr;

            if (mem.req && mem.gnt) begin
                wait_rsp <= 1'b1;
                wait_wr  <= sel_wr;
                if (sel_wr) wr_sent <= 1'b1;
                else        ar_sent <= 1'b1;
            end
            if (mem.rsp_valid) begin
                wait_rsp <= 1'b0;
                if (wait_wr) bvalid <= 1'b1;
                else         rvalid <= 1'b1;
            end

            // Completed responses free their channels
            if (rvalid && rready) begin
                rvalid  <= 1'b0;
                ar_busy <= 1'b0;
                ar_sent <= 1'b0;
            end
            if (bvalid && bready) begin
                bvalid  <= 1'b0;
                aw_busy <= 1'b0;
                w_busy  <= 1'b0;
                wr_sent <= 1'b0;
            end
        end
    end

    // Beat and response payload
    always_ff @(posedge clk) begin
        if (arvalid && arready) begin
            ar_id   <= arid;
            ar_addr <= araddr;
            ar_size <= arsize;
        end
        if (awvalid && awready) begin
            aw_id   <= awid;
            aw_addr <= awaddr;
            aw_size <= awsize;
        end
        if (wvalid && wready) begin
            w_data <= wdata;
            w_strb <= wstrb;
        end
        if (mem.rsp_valid && wait_wr) begin
            bid   <= aw_id;
            bresp <= mem.err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
        end
        if (mem.rsp_valid && !wait_wr) begin
            rid   <= ar_id;
            rdata <= rd_lanes;
            rresp <= mem.err ? axi_mem_pkg::RESP_SLVERR : axi_mem_pkg::RESP_OKAY;
        end
    end

endmodule

`default_nettype wire

/* verilog/mem_req_if.sv */
// Request and reply between one AXI front-end and the shared memory core
// The front-end holds req and its fields until gnt; the core answers with a
// one-cycle rsp_valid pulse on the cycle after the grant
`default_nettype none

interface mem_req_if;

    // Request side
    logic                             req;
    logic                             we;
    logic [axi_mem_pkg::ADDR_W-1:0]   addr;
    logic [axi_mem_pkg::STRB_W-1:0]   be;
    logic [axi_mem_pkg::DATA_W-1:0]   wdata;

    // Reply side
    logic                             gnt;
    logic                             rsp_valid;
    logic [axi_mem_pkg::DATA_W-1:0]   rdata;
    logic                             err;

    modport port (
        output req,
        output we,
        output addr,
        output be,
        output wdata,
        input  gnt,
        input  rsp_valid,
        input  rdata,
        input  err
    );

    modport core (
        input  req,
        input  we,
        input  addr,
        input  be,
        input  wdata,
        output gnt,
        output rsp_valid,
        output rdata,
        output err
    );

endinterface

`default_nettype wire

/* verilog/shared_mem_core.sv */
// Serves two request ports on one byte-lane RAM and the interrupt register
// One request per cycle; on a tie the port not served last wins
// Interrupt register takes lanes 0 and 1 only; error reads return zero
`default_nettype none

module shared_mem_core (
    input  logic                                 clk,
    input  logic                                 rst_n,
    mem_req_if.core                              ip,
    mem_req_if.core                              dp,
    output logic [axi_mem_pkg::IRQ_LINES-1:0]    irq_lines
);

    axi_mem_pkg::mem_word_u            ram [axi_mem_pkg::MEM_WORDS];

    logic                              last_dp;
    logic                              pick_dp;
    logic                              req_any;
    logic                              sel_we;
    logic [axi_mem_pkg::ADDR_W-1:0]    sel_addr;
    logic [axi_mem_pkg::STRB_W-1:0]    sel_be;
    logic                              is_ram;
    logic                              is_irq;
    logic [axi_mem_pkg::MEM_AW-1:0]    idx;
    axi_mem_pkg::mem_word_u            wr_word;
    axi_mem_pkg::mem_word_u            cur_word;
    axi_mem_pkg::mem_word_u            merged;

    logic                              rsp_q;
    logic                              rsp_dp_q;
    logic                              err_q;
    logic [axi_mem_pkg::DATA_W-1:0]    rdata_q;

    // --------------------
    // Arbitration
    // --------------------
    assign pick_dp = dp.req && (!ip.req || !last_dp);
    assign ip.gnt  = ip.req && !pick_dp;
    assign dp.gnt  = pick_dp;
    assign req_any = ip.req || dp.req;

    assign sel_we   = pick_dp ? dp.we   : ip.we;
    assign sel_addr = pick_dp ? dp.addr : ip.addr;
    assign sel_be   = pick_dp ? dp.be   : ip.be;

    // Address decode
    assign is_ram = (sel_addr[axi_mem_pkg::ADDR_W-1:axi_mem_pkg::MEM_AW+2] == '0);
    assign is_irq = (sel_addr == axi_mem_pkg::IRQ_ADDR);
    assign idx    = sel_addr[axi_mem_pkg::MEM_AW+1:2];

    // Old word of the target, with enabled lanes replaced
    always_comb begin
        wr_word.word = pick_dp ? dp.wdata : ip.wdata;
        if (is_irq) begin
            cur_word.word = {{(axi_mem_pkg::DATA_W-axi_mem_pkg::IRQ_LINES){1'b0}}, irq_lines};
        end else if (is_ram) begin
            cur_word = ram[idx];
        end else begin
            cur_word.word = '0;
        end
        merged = cur_word;
        for (int i = 0; i < axi_mem_pkg::STRB_W; i++) begin
            if (sel_be[i]) merged.bytes[i] = wr_word.bytes[i];
        end
    end

    // --------------------
    // Storage and reply
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_dp   <= 1'b0;
            rsp_q     <= 1'b0;
            irq_lines <= '0;
        end else begin
            rsp_q <= req_any;
            if (req_any) last_dp <= pick_dp;
            if (req_any && sel_we && is_irq) begin
                irq_lines <= merged.word[axi_mem_pkg::IRQ_LINES-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_any && sel_we && is_ram) ram[idx] <= merged;
        if (req_any) begin
            rsp_dp_q <= pick_dp;
            err_q    <= !is_ram && !is_irq;
            rdata_q  <= cur_word.word;
        end
    end

    // Reply goes back to whichever port was granted last cycle
    assign ip.rsp_valid = rsp_q && !rsp_dp_q;
    assign dp.rsp_valid = rsp_q && rsp_dp_q;
    assign ip.rdata     = rdata_q;
    assign dp.rdata     = rdata_q;
    assign ip.err       = err_q;
    assign dp.err       = err_q;

endmodule

`default_nettype wire
